// ==== logic/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

    // instruction word geometry
    localparam int WORD_W = 16;

    // four words per line, word 0 in the low bits
    localparam int WORDS_PER_LINE = 4;
    localparam int OFFSET_W = $clog2(WORDS_PER_LINE);

    // one fetched instruction
    typedef logic [WORD_W-1:0] word_t;

    // full cache line as returned by memory
    typedef logic [WORDS_PER_LINE-1:0][WORD_W-1:0] line_t;

    // controller states
    // no write path, so no write-back state
    typedef enum logic [1:0] {
        IDLE,
        COMPARE_TAG,
        ALLOCATE
    } fill_state_e;

endpackage

`default_nettype wire

// ==== logic/cache_access_if.sv ====
`default_nettype none

interface cache_access_if #(
    parameter int LINE_COUNT = 4
);
    import icache_pkg::*;

    localparam int INDEX_W = $clog2(LINE_COUNT);
    localparam int TAG_W = WORD_W - OFFSET_W - INDEX_W;

    // address fields of the request in flight
    logic [INDEX_W-1:0]  index;
    logic [TAG_W-1:0]    tag;
    logic [OFFSET_W-1:0] offset;

    // write strobe for tag and line, one cycle per refill
    logic fill;

    // indexed line valid and tag matches
    logic hit;

    modport ctrl (
        output index,
        output tag,
        output offset,
        output fill,
        input  hit
    );

    modport tag_side (
        input  index,
        input  tag,
        input  fill,
        output hit
    );

    modport data_side (
        input index,
        input offset,
        input fill
    );

endinterface

`default_nettype wire

// ==== logic/icache_tag_store.sv ====
`default_nettype none

module icache_tag_store #(
    parameter int LINE_COUNT = 4
) (
    input  wire logic       clk,
    input  wire logic       reset_n,
    cache_access_if.tag_side acc
);
    import icache_pkg::*;

    localparam int INDEX_W = $clog2(LINE_COUNT);
    localparam int TAG_W = WORD_W - OFFSET_W - INDEX_W;

    // one valid bit per line
    logic [LINE_COUNT-1:0] valid;

    // stored tags
    logic [TAG_W-1:0] tags [LINE_COUNT];

    // reset invalidates every line, cache starts cold
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            valid <= '0;
        end else if (acc.fill) begin
            valid[acc.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (acc.fill) begin
            tags[acc.index] <= acc.tag;
        end
    end

    // combinational lookup, answered in the COMPARE_TAG cycle
    assign acc.hit = valid[acc.index] && (tags[acc.index] == acc.tag);

    // a refilled line must hit on the re-compare,
    // relies on the controller holding the request address
    a_fill_then_hit: assert property (
        @(posedge clk) disable iff (!reset_n)
        acc.fill |=> acc.hit
    ) else $error("tag store: no hit in the cycle after a fill");

endmodule

`default_nettype wire

// ==== logic/icache_line_store.sv ====
`default_nettype none

module icache_line_store #(
    parameter int LINE_COUNT = 4
) (
    input  wire logic           clk,
    input  wire icache_pkg::line_t mem_data,
    output icache_pkg::word_t   cpu_data,
    cache_access_if.data_side   acc
);
    import icache_pkg::*;

    // line data, no reset, valid bits live in the tag store
    line_t lines [LINE_COUNT];

    // whole line written at once on refill
    always_ff @(posedge clk) begin
        if (acc.fill) begin
            lines[acc.index] <= mem_data;
        end
    end

    // word select by offset
    assign cpu_data = lines[acc.index][acc.offset];

endmodule

`default_nettype wire

// ==== logic/icache_fill_ctrl.sv ====
`default_nettype none

module icache_fill_ctrl #(
    parameter int LINE_COUNT = 4
) (
    input  wire logic              clk,
    input  wire logic              reset_n,
    input  wire logic              cpu_valid,
    input  wire icache_pkg::word_t cpu_address,
    input  wire logic              mem_ready,
    output logic                   cpu_ready,
    output logic                   mem_read,
    output icache_pkg::word_t      mem_address,
    cache_access_if.ctrl           acc
);
    import icache_pkg::*;

    localparam int INDEX_W = $clog2(LINE_COUNT);
    localparam int TAG_W = WORD_W - OFFSET_W - INDEX_W;

    fill_state_e state;
    fill_state_e state_next;

    // request address, held until the fetch completes
    word_t req_address;

    always_ff @(posedge clk) begin
        if (state == IDLE && cpu_valid) begin
            req_address <= cpu_address;
        end
    end

    // split into tag / index / offset for the stores
    assign acc.offset = req_address[OFFSET_W-1:0];
    assign acc.index  = req_address[OFFSET_W +: INDEX_W];
    assign acc.tag    = req_address[WORD_W-1 -: TAG_W];

    // line-aligned refill address
    assign mem_address = {req_address[WORD_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

    always_comb begin
        state_next = state;
        unique case (state)
            IDLE: begin
                if (cpu_valid) begin
                    state_next = COMPARE_TAG;
                end
            end
            COMPARE_TAG: begin
                // hit finishes the fetch, miss goes to memory
                if (acc.hit) begin
                    state_next = IDLE;
                end else begin
                    state_next = ALLOCATE;
                end
            end
            ALLOCATE: begin
                // line is written at this edge, then compare again
                if (mem_ready) begin
                    state_next = COMPARE_TAG;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign cpu_ready = (state == COMPARE_TAG) && acc.hit;

    // request raised in the miss cycle itself
    assign mem_read = ((state == COMPARE_TAG) && !acc.hit) || (state == ALLOCATE);

    assign acc.fill = (state == ALLOCATE) && mem_ready;

    // one fetch in flight, new strobes only while idle
    a_valid_in_idle: assert property (
        @(posedge clk) disable iff (!reset_n)
        cpu_valid |-> state == IDLE
    ) else $error("fill ctrl: cpu_valid outside IDLE");

    a_read_held: assert property (
        @(posedge clk) disable iff (!reset_n)
        mem_read && !mem_ready |=> mem_read
    ) else $error("fill ctrl: mem_read dropped before mem_ready");

endmodule

`default_nettype wire

// ==== logic/icache_top.sv ====
`default_nettype none

module icache_top #(
    parameter int LINE_COUNT = 4
) (
    input  wire logic              clk,
    input  wire logic              reset_n,
    // fetch side
    input  wire logic              cpu_valid,
    input  wire icache_pkg::word_t cpu_address,
    output logic                   cpu_ready,
    output icache_pkg::word_t      cpu_data,
    // memory side, one full line per transfer
    output logic                   mem_read,
    output icache_pkg::word_t      mem_address,
    input  wire logic              mem_ready,
    input  wire icache_pkg::line_t mem_data
);

    cache_access_if #(.LINE_COUNT(LINE_COUNT)) acc_if ();

    icache_fill_ctrl #(.LINE_COUNT(LINE_COUNT)) u_fill_ctrl (
        .clk         (clk),
        .reset_n     (reset_n),
        .cpu_valid   (cpu_valid),
        .cpu_address (cpu_address),
        .mem_ready   (mem_ready),
        .cpu_ready   (cpu_ready),
        .mem_read    (mem_read),
        .mem_address (mem_address),
        .acc         (acc_if.ctrl)
    );

    icache_tag_store #(.LINE_COUNT(LINE_COUNT)) u_tag_store (
        .clk     (clk),
        .reset_n (reset_n),
        .acc     (acc_if.tag_side)
    );

    icache_line_store #(.LINE_COUNT(LINE_COUNT)) u_line_store (
        .clk      (clk),
        .mem_data (mem_data),
        .cpu_data (cpu_data),
        .acc      (acc_if.data_side)
    );

endmodule

`default_nettype wire

// ==== tests/icache_tb.sv ====
`default_nettype none

module icache_tb;
    import icache_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int FETCH_LIMIT = 20;
    localparam word_t DATA_KEY = 16'hc3a5;

    logic  clk = 1'b0;
    logic  reset_n;
    logic  cpu_valid;
    word_t cpu_address;
    logic  cpu_ready;
    word_t cpu_data;
    logic  mem_read;
    word_t mem_address;
    logic  mem_ready;
    line_t mem_data;

    // trace entries, loaded before reset
    logic [7:0] kinds [$];
    word_t      addrs [$];
    bit         hit_flags [$];
    bit         trace_loaded = 1'b0;

    int check_count = 0;
    int value_errors = 0;
    int timing_errors = 0;
    int setup_errors = 0;

    logic [31:0] lcg_state = 32'hd7923919;

    icache_top #(.LINE_COUNT(4)) UUT (
        .clk         (clk),
        .reset_n     (reset_n),
        .cpu_valid   (cpu_valid),
        .cpu_address (cpu_address),
        .cpu_ready   (cpu_ready),
        .cpu_data    (cpu_data),
        .mem_read    (mem_read),
        .mem_address (mem_address),
        .mem_ready   (mem_ready),
        .mem_data    (mem_data)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // memory contents: each word is its own address scrambled
    function automatic word_t mem_word(input word_t address);
        return address ^ DATA_KEY;
    endfunction

    function automatic line_t read_line(input word_t base);
        line_t line;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            line[w] = mem_word(base + word_t'(w));
        end
        return line;
    endfunction

    task automatic compare_word(input word_t actual, input word_t expected,
                                input string what);
        check_count++;
        assert (actual === expected) else begin
            value_errors++;
            $display("error: %0t %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic expect_level(input logic actual, input logic expected,
                                input string what);
        check_count++;
        assert (actual === expected) else begin
            timing_errors++;
            $display("error: %0t %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic apply_reset();
        reset_n = 1'b0;
        cpu_valid = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset_n = 1'b1;
        expect_level(cpu_ready, 1'b0, "cpu_ready after reset");
        expect_level(mem_read, 1'b0, "mem_read after reset");
    endtask

    task automatic run_fetch(input word_t address, input bit expect_hit);
        word_t line_address;
        line_address = address & ~word_t'(WORDS_PER_LINE - 1);
        cpu_address = address;
        cpu_valid = 1'b1;
        @(negedge clk);
        cpu_valid = 1'b0;
        // first cycle after the strobe edge
        if (expect_hit) begin
            expect_level(cpu_ready, 1'b1, $sformatf("cpu_ready on hit to %h", address));
            expect_level(mem_read, 1'b0, $sformatf("mem_read on hit to %h", address));
        end else begin
            expect_level(cpu_ready, 1'b0, $sformatf("cpu_ready on miss to %h", address));
            expect_level(mem_read, 1'b1, $sformatf("mem_read on miss to %h", address));
            compare_word(mem_address, line_address,
                         $sformatf("mem_address on miss to %h", address));
        end
        for (int waited = 0; waited < FETCH_LIMIT && !cpu_ready; waited++) begin
            @(negedge clk);
        end
        check_count++;
        assert (cpu_ready) else begin
            timing_errors++;
            $display("fetch of address %h got no cpu_ready within %0d cycles",
                     address, FETCH_LIMIT);
        end
        if (cpu_ready) begin
            compare_word(cpu_data, mem_word(address), $sformatf("cpu_data for %h", address));
        end
        // controller back in IDLE before the next strobe
        @(negedge clk);
    endtask

    // line reads answered after 1 to 8 cycles
    initial begin : memory_model
        int delay;
        mem_ready = 1'b0;
        mem_data = '0;
        forever begin
            @(negedge clk);
            mem_ready = 1'b0;
            if (reset_n && mem_read) begin
                delay = int'(lcg_next() >> 16) % 8 + 1;
                repeat (delay) @(negedge clk);
                mem_data = read_line(mem_address);
                mem_ready = 1'b1;
            end
        end
    end

    initial begin : watchdog
        int limit;
        wait (trace_loaded);
        limit = kinds.size() * 20 + 100;
        repeat (limit) @(posedge clk);
        $display("watchdog: the run did not finish within %0d cycles", limit);
        $display("Test failed");
        $finish;
    end

    initial begin : main
        int fd;
        int fields;
        logic [7:0] kind;
        word_t address;
        int flag;
        logic [8*128-1:0] text;
        bit done;

        cpu_valid = 1'b0;
        cpu_address = '0;
        reset_n = 1'b0;
        done = 1'b0;

        fd = $fopen("tests/icache_trace.txt", "r");
        if (fd == 0) begin
            setup_errors++;
            $display("could not open the trace file tests/icache_trace.txt");
        end else begin
            while (!done) begin
                fields = $fscanf(fd, " %c", kind);
                if (fields != 1) begin
                    done = 1'b1;
                end else if (kind == "#") begin
                    // comment line, skip the rest of it
                    fields = $fgets(text, fd);
                end else begin
                    fields = $fscanf(fd, "%h %d", address, flag);
                    if (fields == 2 && (kind == "F" || kind == "R")) begin
                        kinds.push_back(kind);
                        addrs.push_back(address);
                        hit_flags.push_back(flag != 0);
                    end else begin
                        setup_errors++;
                        $display("trace entry %0d could not be read", kinds.size());
                        done = 1'b1;
                    end
                end
            end
            $fclose(fd);
            if (kinds.size() == 0) begin
                setup_errors++;
                $display("the trace file holds no entries");
            end
        end
        trace_loaded = 1'b1;

        @(negedge clk);
        apply_reset();
        for (int i = 0; i < kinds.size(); i++) begin
            if (kinds[i] == "R") begin
                apply_reset();
            end else begin
                run_fetch(addrs[i], hit_flags[i]);
            end
        end

        $display("checks: %0d, value errors: %0d, timing errors: %0d, setup errors: %0d",
                 check_count, value_errors, timing_errors, setup_errors);
        if (value_errors + timing_errors + setup_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/icache_trace.txt ====
# columns: kind (F fetch, R reset), word address in hex, expected hit flag (1 hit, 0 miss)
# flags follow a direct-mapped cache of 4 lines x 4 words, cold after every reset
# first touch of each line
F 0000 0
F 0001 1
F 0003 1
F 0004 0
F 0006 1
F 0008 0
F 000c 0
F 000b 1
F 0002 1
# conflicts on index 0
F 0010 0
F 0011 1
F 0000 0
F 0013 0
F 0005 1
F 0007 1
# conflicts on index 1 and 3
F 1234 0
F 1235 1
F 0004 0
F 000f 1
F abcd 0
F abce 1
F 000e 0
F 0009 1
# reset mid-run, every line cold again
R 0000 0
F 0009 0
F 000a 1
F 0000 0
F 0001 1
F 0005 0
F 000d 0
F ffff 0
F fffc 1
F 000d 0
F 000c 1

// ==== list.f ====
logic/icache_pkg.sv
logic/cache_access_if.sv
logic/icache_tag_store.sv
logic/icache_line_store.sv
logic/icache_fill_ctrl.sv
logic/icache_top.sv
tests/icache_tb.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - logic/icache_pkg.sv
  - logic/cache_access_if.sv
  - logic/icache_tag_store.sv
  - logic/icache_line_store.sv
  - logic/icache_fill_ctrl.sv
  - logic/icache_top.sv
  - target: test
    files:
      - tests/icache_tb.sv
